//--- vlog.f
+incdir+design
+incdir+tests
design/axi_addr_pkg.sv
design/trace_stream_pkg.sv
design/addr_tap.sv
design/trace_arbiter.sv
design/addr_trace_mirror.sv
tests/mirror_tb.sv

//--- run.sh
#!/bin/sh
# builds the address trace mirror testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Mdir obj_dir \
  --top-module mirror_tb -f vlog.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build stopped with status $status"
  exit $status
fi

./obj_dir/Vmirror_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation stopped with status $status"
  exit $status
fi
exit 0

//--- tests/mirror_table.svh
// each row holds the channel, the enables, the beats it should add to the trace,
// the burst length, the m_ax_ready stall and the tready pattern
// chan is 1 for AR, 2 for AW and 3 for both, en is {aw_enable, ar_enable}
// the tready pattern is applied lsb first, one bit per cycle, and then ones follow
localparam int row_count = 14;

localparam logic [39:0] stim_table [row_count] = '{
  //chan  en     beats  len     stall  tready
  // plain transfers, the second with a stalled subordinate
  {2'd1, 2'b11, 4'd1, 8'd0,   8'd0, 16'hffff},
  {2'd2, 2'b11, 4'd1, 8'd3,   8'd2, 16'hffff},
  {2'd1, 2'b11, 4'd1, 8'd7,   8'd0, 16'h5555},
  // tready held low so the second AR address has to wait for the first beat
  {2'd1, 2'b11, 4'd1, 8'd1,   8'd0, 16'h0000},
  {2'd1, 2'b11, 4'd1, 8'd2,   8'd0, 16'h0000},
  // AW disabled, its addresses pass through untraced
  {2'd2, 2'b01, 4'd0, 8'd15,  8'd1, 16'hffff},
  {2'd2, 2'b01, 4'd0, 8'd0,   8'd0, 16'h0000},
  // both channels hold records at once and their beats must alternate
  {2'd3, 2'b11, 4'd2, 8'd4,   8'd0, 16'hfff0},
  {2'd3, 2'b11, 4'd2, 8'd5,   8'd0, 16'h0000},
  {2'd3, 2'b11, 4'd2, 8'd6,   8'd3, 16'hff00},
  // AR disabled while AW keeps tracing
  {2'd1, 2'b10, 4'd0, 8'd2,   8'd0, 16'hffff},
  {2'd3, 2'b10, 4'd1, 8'd9,   8'd1, 16'h00f0},
  {2'd2, 2'b11, 4'd1, 8'd0,   8'd0, 16'h0001},
  {2'd3, 2'b11, 4'd2, 8'd255, 8'd2, 16'haaaa}
};

//--- tests/mirror_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mirror_consts.svh"

module mirror_tb;

  `include "mirror_table.svh"

  // channel tags as the beat layout places them in the top nibble
  localparam logic [3:0] tag_ar = 4'd1;
  localparam logic [3:0] tag_aw = 4'd2;

  logic clk;
  logic resetn;
  logic ar_enable;
  logic aw_enable;
  logic [`MIRROR_ID_W-1:0] s_ar_id, m_ar_id, s_aw_id, m_aw_id;
  logic [`MIRROR_ADDR_W-1:0] s_ar_addr, m_ar_addr, s_aw_addr, m_aw_addr;
  logic [`MIRROR_LEN_W-1:0] s_ar_len, m_ar_len, s_aw_len, m_aw_len;
  logic [2:0] s_ar_size, m_ar_size, s_aw_size, m_aw_size;
  logic [1:0] s_ar_burst, m_ar_burst, s_aw_burst, m_aw_burst;
  logic s_ar_valid, s_ar_ready, m_ar_valid, m_ar_ready;
  logic s_aw_valid, s_aw_ready, m_aw_valid, m_aw_ready;
  logic [`MIRROR_TDATA_W-1:0] trace_tdata;
  logic [`MIRROR_TDATA_W/8-1:0] trace_tkeep;
  logic trace_tlast;
  logic trace_tvalid;
  logic trace_tready;

  // reference model of the records each tap still has to send
  logic [`MIRROR_TDATA_W-1:0] ar_q[$];
  logic [`MIRROR_TDATA_W-1:0] aw_q[$];
  logic backoff_exp;
  logic prefer_aw_exp;
  logic offer_hold;
  logic offer_aw;
  int beat_count;
  logic [31:0] lfsr_state;

  addr_trace_mirror addr_trace_mirror_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // taps 32, 22, 2 and 1 give a maximal length sequence
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic take_random(input int nbits, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // beat layout is tag, id, len, a zero gap and then the address
  function automatic logic [`MIRROR_TDATA_W-1:0] build_beat(input logic [3:0] tag,
      input logic [`MIRROR_ID_W-1:0] id, input logic [`MIRROR_LEN_W-1:0] len,
      input logic [`MIRROR_ADDR_W-1:0] addr);
    return {tag, id, len, {(`MIRROR_LEN_LSB-`MIRROR_ADDR_W){1'b0}}, addr};
  endfunction

  task automatic load_address(output logic [`MIRROR_ID_W-1:0] id,
      output logic [`MIRROR_ADDR_W-1:0] addr, output logic [2:0] size,
      output logic [1:0] burst);
    logic [31:0] rnd;
    take_random(`MIRROR_ID_W, rnd);
    id = rnd[`MIRROR_ID_W-1:0];
    take_random(`MIRROR_ADDR_W, rnd);
    addr = rnd;
    take_random(3, rnd);
    size = rnd[2:0];
    take_random(2, rnd);
    burst = rnd[1:0];
  endtask

  // a tap blocks only while it is enabled and still holds a record
  task automatic check_path(input string ch, input logic blk, input logic [48:0] s_fields,
      input logic [48:0] m_fields, input logic s_valid, input logic m_valid,
      input logic m_ready, input logic s_ready);
    check($sformatf("m_%s_{id,addr,len,size,burst}", ch), 64'(m_fields), 64'(s_fields));
    check($sformatf("m_%s_valid", ch), 64'(m_valid), 64'(s_valid && !blk));
    check($sformatf("s_%s_ready", ch), 64'(s_ready), 64'(m_ready && !blk));
  endtask

  task automatic check_stream();
    logic want_valid;
    logic [`MIRROR_TDATA_W-1:0] want_beat;
    want_valid = (ar_q.size() != 0 || aw_q.size() != 0) && !backoff_exp;
    check("trace_tvalid", 64'(trace_tvalid), 64'(want_valid));
    backoff_exp = 1'b0;
    if (want_valid) begin
      // a new offer goes to the channel that lost the last transfer when both wait
      if (!offer_hold) begin
        offer_aw = aw_q.size() != 0 && (ar_q.size() == 0 || prefer_aw_exp);
      end
      want_beat = offer_aw ? aw_q[0] : ar_q[0];
      check("trace_tdata", trace_tdata, want_beat);
      check("trace_tkeep", 64'(trace_tkeep), 64'({(`MIRROR_TDATA_W/8){1'b1}}));
      check("trace_tlast", 64'(trace_tlast), 64'(1'b1));
      if (trace_tready) begin
        if (offer_aw) begin
          void'(aw_q.pop_front());
        end else begin
          void'(ar_q.pop_front());
        end
        prefer_aw_exp = !offer_aw;
        offer_hold = 1'b0;
        backoff_exp = 1'b1;
        beat_count++;
      end else begin
        offer_hold = 1'b1;
      end
    end
  endtask

  // all checks see the queues as they were before this edge
  always @(posedge clk) begin
    if (resetn) begin
      ar_q.delete();
      aw_q.delete();
      backoff_exp = 1'b0;
      prefer_aw_exp = 1'b0;
      offer_hold = 1'b0;
      offer_aw = 1'b0;
      beat_count = 0;
    end else begin
      check_path("ar", ar_enable && ar_q.size() != 0,
        {s_ar_id, s_ar_addr, s_ar_len, s_ar_size, s_ar_burst},
        {m_ar_id, m_ar_addr, m_ar_len, m_ar_size, m_ar_burst},
        s_ar_valid, m_ar_valid, m_ar_ready, s_ar_ready);
      check_path("aw", aw_enable && aw_q.size() != 0,
        {s_aw_id, s_aw_addr, s_aw_len, s_aw_size, s_aw_burst},
        {m_aw_id, m_aw_addr, m_aw_len, m_aw_size, m_aw_burst},
        s_aw_valid, m_aw_valid, m_aw_ready, s_aw_ready);
      check_stream();
      if (s_ar_valid && s_ar_ready && ar_enable) begin
        ar_q.push_back(build_beat(tag_ar, s_ar_id, s_ar_len, s_ar_addr));
      end
      if (s_aw_valid && s_aw_ready && aw_enable) begin
        aw_q.push_back(build_beat(tag_aw, s_aw_id, s_aw_len, s_aw_addr));
      end
    end
  end

  // one row offers its addresses and steps tready until every handshake is done
  task automatic run_row(input int r);
    logic [39:0] row;
    logic ar_busy;
    logic aw_busy;
    logic [7:0] stall_left;
    logic [15:0] pattern;
    row = stim_table[r];
    ar_busy = row[38];
    aw_busy = row[39];
    stall_left = row[23:16];
    pattern = row[15:0];
    @(negedge clk);
    ar_enable = row[36];
    aw_enable = row[37];
    if (ar_busy) begin
      load_address(s_ar_id, s_ar_addr, s_ar_size, s_ar_burst);
      s_ar_len = row[31:24];
      s_ar_valid = 1'b1;
    end
    if (aw_busy) begin
      load_address(s_aw_id, s_aw_addr, s_aw_size, s_aw_burst);
      s_aw_len = row[31:24];
      s_aw_valid = 1'b1;
    end
    while (ar_busy || aw_busy) begin
      m_ar_ready = (stall_left == 8'd0);
      m_aw_ready = (stall_left == 8'd0);
      trace_tready = pattern[0];
      pattern = {1'b1, pattern[15:1]};
      if (stall_left != 8'd0) begin
        stall_left = stall_left - 8'd1;
      end
      @(posedge clk);
      if (s_ar_valid && s_ar_ready) begin
        ar_busy = 1'b0;
      end
      if (s_aw_valid && s_aw_ready) begin
        aw_busy = 1'b0;
      end
      @(negedge clk);
      s_ar_valid = s_ar_valid && ar_busy;
      s_aw_valid = s_aw_valid && aw_busy;
    end
  endtask

  initial begin
    repeat (row_count * 40) @(posedge clk);
    fail_run("timeout, the trace did not drain within the cycle budget");
  end

  initial begin
    int r;
    int total;
    lfsr_state = 32'h7e37_f18f;
    resetn = 1'b1;
    ar_enable = 1'b0;
    aw_enable = 1'b0;
    {s_ar_id, s_ar_addr, s_ar_len, s_ar_size, s_ar_burst, s_ar_valid} = '0;
    {s_aw_id, s_aw_addr, s_aw_len, s_aw_size, s_aw_burst, s_aw_valid} = '0;
    m_ar_ready = 1'b1;
    m_aw_ready = 1'b1;
    trace_tready = 1'b0;
    total = 0;
    // two rising edges see the reset before it is released on a falling edge
    repeat (2) @(posedge clk);
    @(negedge clk);
    resetn = 1'b0;
    for (r = 0; r < row_count; r++) begin
      total += int'(stim_table[r][35:32]);
      run_row(r);
    end
    trace_tready = 1'b1;
    while (ar_q.size() != 0 || aw_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    check("trace beat count", 64'(beat_count), 64'(total));
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/addr_trace_mirror.sv
`timescale 1ns/1ps
`default_nettype none

// address channel mirror for an AXI4 link
// AR and AW pass through two taps and every accepted address is copied
// as one beat onto the trace stream
module addr_trace_mirror
  import axi_addr_pkg::*;
  import trace_stream_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  logic        ar_enable,
  input  logic        aw_enable,
  // read address channel from the manager
  input  axi_id_t     s_ar_id,
  input  axi_addr_t   s_ar_addr,
  input  axi_len_t    s_ar_len,
  input  axi_size_t   s_ar_size,
  input  axi_burst_t  s_ar_burst,
  input  logic        s_ar_valid,
  output logic        s_ar_ready,
  // read address channel towards the subordinate
  output axi_id_t     m_ar_id,
  output axi_addr_t   m_ar_addr,
  output axi_len_t    m_ar_len,
  output axi_size_t   m_ar_size,
  output axi_burst_t  m_ar_burst,
  output logic        m_ar_valid,
  input  logic        m_ar_ready,
  // write address channel from the manager
  input  axi_id_t     s_aw_id,
  input  axi_addr_t   s_aw_addr,
  input  axi_len_t    s_aw_len,
  input  axi_size_t   s_aw_size,
  input  axi_burst_t  s_aw_burst,
  input  logic        s_aw_valid,
  output logic        s_aw_ready,
  // write address channel towards the subordinate
  output axi_id_t     m_aw_id,
  output axi_addr_t   m_aw_addr,
  output axi_len_t    m_aw_len,
  output axi_size_t   m_aw_size,
  output axi_burst_t  m_aw_burst,
  output logic        m_aw_valid,
  input  logic        m_aw_ready,
  // trace stream
  output trace_data_t trace_tdata,
  output trace_keep_t trace_tkeep,
  output logic        trace_tlast,
  output logic        trace_tvalid,
  input  logic        trace_tready
);

  // records on their way from the taps to the arbiter
  logic      ar_rec_valid;
  axi_id_t   ar_rec_id;
  axi_addr_t ar_rec_addr;
  axi_len_t  ar_rec_len;
  logic      ar_rec_take;

  logic      aw_rec_valid;
  axi_id_t   aw_rec_id;
  axi_addr_t aw_rec_addr;
  axi_len_t  aw_rec_len;
  logic      aw_rec_take;

  addr_tap ar_tap_i (
    .clk        (clk),
    .resetn     (resetn),
    .enable     (ar_enable),
    .s_ax_id    (s_ar_id),
    .s_ax_addr  (s_ar_addr),
    .s_ax_len   (s_ar_len),
    .s_ax_size  (s_ar_size),
    .s_ax_burst (s_ar_burst),
    .s_ax_valid (s_ar_valid),
    .s_ax_ready (s_ar_ready),
    .m_ax_id    (m_ar_id),
    .m_ax_addr  (m_ar_addr),
    .m_ax_len   (m_ar_len),
    .m_ax_size  (m_ar_size),
    .m_ax_burst (m_ar_burst),
    .m_ax_valid (m_ar_valid),
    .m_ax_ready (m_ar_ready),
    .rec_valid  (ar_rec_valid),
    .rec_id     (ar_rec_id),
    .rec_addr   (ar_rec_addr),
    .rec_len    (ar_rec_len),
    .rec_take   (ar_rec_take)
  );

  addr_tap aw_tap_i (
    .clk        (clk),
    .resetn     (resetn),
    .enable     (aw_enable),
    .s_ax_id    (s_aw_id),
    .s_ax_addr  (s_aw_addr),
    .s_ax_len   (s_aw_len),
    .s_ax_size  (s_aw_size),
    .s_ax_burst (s_aw_burst),
    .s_ax_valid (s_aw_valid),
    .s_ax_ready (s_aw_ready),
    .m_ax_id    (m_aw_id),
    .m_ax_addr  (m_aw_addr),
    .m_ax_len   (m_aw_len),
    .m_ax_size  (m_aw_size),
    .m_ax_burst (m_aw_burst),
    .m_ax_valid (m_aw_valid),
    .m_ax_ready (m_aw_ready),
    .rec_valid  (aw_rec_valid),
    .rec_id     (aw_rec_id),
    .rec_addr   (aw_rec_addr),
    .rec_len    (aw_rec_len),
    .rec_take   (aw_rec_take)
  );

  // one arbiter serves both taps in round-robin order
  trace_arbiter trace_arbiter_i (
    .clk      (clk),
    .resetn   (resetn),
    .ar_valid (ar_rec_valid),
    .ar_id    (ar_rec_id),
    .ar_addr  (ar_rec_addr),
    .ar_len   (ar_rec_len),
    .ar_take  (ar_rec_take),
    .aw_valid (aw_rec_valid),
    .aw_id    (aw_rec_id),
    .aw_addr  (aw_rec_addr),
    .aw_len   (aw_rec_len),
    .aw_take  (aw_rec_take),
    .tdata    (trace_tdata),
    .tkeep    (trace_tkeep),
    .tlast    (trace_tlast),
    .tvalid   (trace_tvalid),
    .tready   (trace_tready)
  );

endmodule

`default_nettype wire

//--- design/trace_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mirror_consts.svh"

// merges the AR and AW records onto one AXI4-Stream output
// each record becomes a single beat with tlast set and the bus rests for
// one cycle after every beat
module trace_arbiter
  import trace_stream_pkg::*;
(
  input  logic                     clk,
  input  logic                     resetn,
  // AR record
  input  logic                     ar_valid,
  input  logic [`MIRROR_ID_W-1:0]   ar_id,
  input  logic [`MIRROR_ADDR_W-1:0] ar_addr,
  input  logic [`MIRROR_LEN_W-1:0]  ar_len,
  output logic                     ar_take,
  // AW record
  input  logic                     aw_valid,
  input  logic [`MIRROR_ID_W-1:0]   aw_id,
  input  logic [`MIRROR_ADDR_W-1:0] aw_addr,
  input  logic [`MIRROR_LEN_W-1:0]  aw_len,
  output logic                     aw_take,
  // trace stream
  output trace_data_t              tdata,
  output trace_keep_t              tkeep,
  output logic                     tlast,
  output logic                     tvalid,
  input  logic                     tready
);

  // set when AR won the last transfer, so AW goes first on a tie
  logic prefer_aw;
  // high for the one cycle that follows a beat with tlast
  logic backoff;
  // the grant is frozen while an offered beat waits for tready
  logic locked;
  logic locked_aw;

  logic        sel_aw;
  logic        xfer;
  trace_chan_e tag;

  // a beat that is already on the bus keeps its channel even if the other
  // record turns up in the meantime
  always_comb begin
    if (locked) begin
      sel_aw = locked_aw;
    end else begin
      sel_aw = aw_valid & (~ar_valid | prefer_aw);
    end
  end

  assign tvalid = (ar_valid | aw_valid) & ~backoff;
  assign xfer   = tvalid & tready;

  // the tap clears its record on the same edge as the stream transfer
  assign ar_take = xfer & ~sel_aw;
  assign aw_take = xfer & sel_aw;

  assign tag = sel_aw ? CHAN_AW : CHAN_AR;

  // beat assembly, unused bits between len and addr stay zero
  always_comb begin
    tdata = '0;
    tdata[`MIRROR_TAG_LSB +: $bits(trace_chan_e)] = tag;
    if (sel_aw) begin
      tdata[`MIRROR_ID_LSB +: `MIRROR_ID_W]   = aw_id;
      tdata[`MIRROR_LEN_LSB +: `MIRROR_LEN_W] = aw_len;
      tdata[0 +: `MIRROR_ADDR_W]              = aw_addr;
    end else begin
      tdata[`MIRROR_ID_LSB +: `MIRROR_ID_W]   = ar_id;
      tdata[`MIRROR_LEN_LSB +: `MIRROR_LEN_W] = ar_len;
      tdata[0 +: `MIRROR_ADDR_W]              = ar_addr;
    end
  end

  // every transaction fits in one beat and all bytes are meaningful
  assign tkeep = '1;
  assign tlast = 1'b1;

  // round-robin pointer, which only moves when a beat really leaves
  always_ff @(posedge clk) begin
    if (resetn) begin
      prefer_aw <= 1'b0;
    end else if (xfer) begin
      prefer_aw <= ~sel_aw;
    end
  end

  // hold the grant from the first cycle a beat is offered until it transfers
  always_ff @(posedge clk) begin
    if (resetn) begin
      locked    <= 1'b0;
      locked_aw <= 1'b0;
    end else if (xfer) begin
      locked <= 1'b0;
    end else if (tvalid) begin
      locked    <= 1'b1;
      locked_aw <= sel_aw;
    end
  end

  // drop tvalid for one cycle after each completed packet so that tlast
  // never changes under a high tvalid
  always_ff @(posedge clk) begin
    if (resetn) begin
      backoff <= 1'b0;
    end else begin
      backoff <= xfer & tlast;
    end
  end

endmodule

`default_nettype wire

//--- design/addr_tap.sv
`timescale 1ns/1ps
`default_nettype none

// taps one AXI4 address channel
// the channel passes straight through while a one-entry record keeps the
// last accepted id, addr and len until the arbiter has sent it as a beat
module addr_tap
  import axi_addr_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  logic       enable,
  // subordinate side, driven by the outside manager
  input  axi_id_t    s_ax_id,
  input  axi_addr_t  s_ax_addr,
  input  axi_len_t   s_ax_len,
  input  axi_size_t  s_ax_size,
  input  axi_burst_t s_ax_burst,
  input  logic       s_ax_valid,
  output logic       s_ax_ready,
  // manager side, received by the outside subordinate
  output axi_id_t    m_ax_id,
  output axi_addr_t  m_ax_addr,
  output axi_len_t   m_ax_len,
  output axi_size_t  m_ax_size,
  output axi_burst_t m_ax_burst,
  output logic       m_ax_valid,
  input  logic       m_ax_ready,
  // record towards the arbiter
  output logic       rec_valid,
  output axi_id_t    rec_id,
  output axi_addr_t  rec_addr,
  output axi_len_t   rec_len,
  input  logic       rec_take
);

  logic block;
  logic handshake;

  // the payload is never touched on its way through
  assign m_ax_id    = s_ax_id;
  assign m_ax_addr  = s_ax_addr;
  assign m_ax_len   = s_ax_len;
  assign m_ax_size  = s_ax_size;
  assign m_ax_burst = s_ax_burst;

  // a held record closes the channel so that no transaction goes untraced
  // a disabled tap never blocks, it only stops recording
  assign block = enable & rec_valid;

  // valid and ready are both gated so the two sides agree on every transfer
  assign m_ax_valid = s_ax_valid & ~block;
  assign s_ax_ready = m_ax_ready & ~block;

  assign handshake = s_ax_valid & s_ax_ready;

  // record occupancy
  // capture and take cannot meet in one cycle since an enabled full tap blocks
  always_ff @(posedge clk) begin
    if (resetn) begin
      rec_valid <= 1'b0;
    end else if (rec_take) begin
      rec_valid <= 1'b0;
    end else if (enable && handshake) begin
      rec_valid <= 1'b1;
    end
  end

  // record payload, only loaded together with the occupancy flag
  always_ff @(posedge clk) begin
    if (enable && handshake) begin
      rec_id   <= s_ax_id;
      rec_addr <= s_ax_addr;
      rec_len  <= s_ax_len;
    end
  end

endmodule

`default_nettype wire

//--- design/trace_stream_pkg.sv
`default_nettype none

`include "mirror_consts.svh"

// types of the AXI4-Stream trace output
package trace_stream_pkg;

  typedef logic [`MIRROR_TDATA_W-1:0] trace_data_t;

  // one keep bit per data byte
  typedef logic [`MIRROR_TDATA_W/8-1:0] trace_keep_t;

  // tag in the top nibble of each beat that names the source channel
  // zero is left unused so an idle bus never looks like a valid tag
  typedef enum logic [3:0] {
    CHAN_AR = 4'd1,
    CHAN_AW = 4'd2
  } trace_chan_e;

endpackage

`default_nettype wire

//--- design/axi_addr_pkg.sv
`default_nettype none

`include "mirror_consts.svh"

// field types of an AXI4 address channel, shared by AR and AW
package axi_addr_pkg;

  typedef logic [`MIRROR_ADDR_W-1:0] axi_addr_t;
  typedef logic [`MIRROR_ID_W-1:0] axi_id_t;

  // number of data beats minus one
  typedef logic [`MIRROR_LEN_W-1:0] axi_len_t;

  // size and burst keep their fixed AXI4 widths
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_burst_t;

endpackage

`default_nettype wire

//--- design/mirror_consts.svh
`ifndef MIRROR_CONSTS_SVH
`define MIRROR_CONSTS_SVH

// widths of the AXI address channel fields that are passed through
`define MIRROR_ADDR_W 32
`define MIRROR_ID_W 4
`define MIRROR_LEN_W 8

// one trace beat carries a whole address transaction
`define MIRROR_TDATA_W 64

// beat layout from the top down
// tag sits in bits 63 to 60, id in 59 to 56 and len in 55 to 48
`define MIRROR_TAG_LSB 60
`define MIRROR_ID_LSB 56
`define MIRROR_LEN_LSB 48

// bits 47 to 32 stay zero and the address fills bits 31 to 0

`endif
